// ==== list.f ====
hdl/layer_cfg_pkg.sv
hdl/layer_mem_pkg.sv
hdl/pixel_word_if.sv
hdl/layer_regs.sv
hdl/bitmap_fetch.sv
hdl/pixel_unpack.sv
hdl/layer_renderer.sv
tests/tb_layer_renderer.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the layer renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module tb_layer_renderer \
    -o tb_layer_renderer
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_layer_renderer 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^test passed$"; then
    exit 0
fi
exit 1

// ==== tests/tb_layer_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_layer_renderer
    import layer_cfg_pkg::*;
    import layer_mem_pkg::*;
();

    localparam int LINE_PIXELS  = 640;
    localparam int LINE_TIMEOUT = 5000;    // Cycles allowed per line

    logic      clk = 1'b0;
    logic      rst;
    logic      start_of_screen;
    logic      start_of_line;
    reg_addr_t regs_addr;
    logic [7:0] regs_wrdata;
    logic      regs_write;
    logic [7:0] regs_rddata;
    bus_addr_t bus_addr;
    logic      bus_strobe;
    bus_word_t bus_rddata;
    logic      bus_ack;
    lb_idx_t   linebuf_wridx;
    pixel_t    linebuf_wrdata;
    logic      linebuf_wren;

    bus_word_t   mem [0:65535];
    logic [31:0] rng_state;
    int          errors = 0;
    int          timeouts = 0;
    int          wr_count = 0;     // Line buffer writes on current line
    int          fetch_idx = 0;    // Bus reads on current line
    int          strobe_cnt = 0;
    int          cur_line = 0;     // Lines since start_of_screen

    // Expected configuration
    int          cfg_bpp = 8;
    int          cfg_hscale = 0;
    int          cfg_vscale = 0;
    int          cfg_base = 0;
    int          cfg_stride = 0;
    logic [3:0]  cfg_pal = 4'd0;

    layer_renderer #(
        .LINE_PIXELS (LINE_PIXELS)
    ) i_dut (
        .clk             (clk),
        .rst             (rst),
        .start_of_screen (start_of_screen),
        .start_of_line   (start_of_line),
        .regs_addr       (regs_addr),
        .regs_wrdata     (regs_wrdata),
        .regs_write      (regs_write),
        .regs_rddata     (regs_rddata),
        .bus_addr        (bus_addr),
        .bus_strobe      (bus_strobe),
        .bus_rddata      (bus_rddata),
        .bus_ack         (bus_ack),
        .linebuf_wridx   (linebuf_wridx),
        .linebuf_wrdata  (linebuf_wrdata),
        .linebuf_wren    (linebuf_wren)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Pixel idx of display line line_no from memory and the expected config
    function automatic pixel_t expected_pixel(input int line_no, input int idx);
        int         per_byte;
        int         ppw;
        int         p;
        int         x;
        int         off;
        bus_addr_t  addr;
        bus_word_t  word;
        logic [7:0] raw;
        per_byte = 8 / cfg_bpp;
        ppw      = 32 / cfg_bpp;
        p        = idx / (cfg_hscale + 1);    // Source pixel
        x        = p % ppw;
        addr     = bus_addr_t'(cfg_base + (line_no / (cfg_vscale + 1)) * cfg_stride + p / ppw);
        word     = mem[addr];
        off      = (x / per_byte) * 8 + (per_byte - 1 - x % per_byte) * cfg_bpp;
        raw      = 8'((word >> off) & ((32'd1 << cfg_bpp) - 32'd1));
        if (cfg_bpp < 8 && raw != 8'd0)
            raw[7:4] = cfg_pal;
        return raw;
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        errors++;
        $display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    endtask

    //////////////////////////////
    // Bus memory model
    //////////////////////////////

    always begin : bus_model
        bus_addr_t req_addr;
        bus_addr_t exp_addr;
        int        delay;
        @(posedge clk);
        #1;
        if (bus_strobe) begin
            req_addr = bus_addr;
            // Word fetch_idx of the current source line
            exp_addr = bus_addr_t'(cfg_base + (cur_line / (cfg_vscale + 1)) * cfg_stride
                                   + fetch_idx);
            assert (req_addr == exp_addr)
                else report_mismatch("bus_addr", int'(req_addr), int'(exp_addr));
            fetch_idx++;
            rng_state = lcg_next(rng_state);
            delay     = int'(rng_state[17:16]);    // 0 to 3 cycles
            repeat (delay) begin
                @(posedge clk);
                #1;
            end
            bus_rddata = mem[req_addr];
            bus_ack    = 1'b1;
            @(posedge clk);
            #1;
            bus_ack = 1'b0;
        end
    end

    // Every line buffer write against the reference
    always @(negedge clk) begin : compare
        pixel_t exp_pix;
        if (!rst) begin
            if (bus_strobe)
                strobe_cnt++;
            if (linebuf_wren) begin
                exp_pix = expected_pixel(cur_line, wr_count);
                assert (int'(linebuf_wridx) == wr_count)
                    else report_mismatch("linebuf_wridx", int'(linebuf_wridx), wr_count);
                assert (linebuf_wrdata == exp_pix)
                    else report_mismatch("linebuf_wrdata", int'(linebuf_wrdata), int'(exp_pix));
                wr_count++;
            end
        end
    end

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    task automatic write_reg(input reg_addr_t a, input logic [7:0] d);
        @(posedge clk);
        #1;
        regs_addr   = a;
        regs_wrdata = d;
        regs_write  = 1'b1;
        @(posedge clk);
        #1;
        regs_write = 1'b0;
    endtask

    task automatic check_reg(input reg_addr_t a, input logic [7:0] exp);
        @(posedge clk);
        #1;
        regs_addr  = a;
        regs_write = 1'b0;
        @(negedge clk);    // Readback is combinational
        assert (regs_rddata == exp)
            else report_mismatch("regs_rddata", int'(regs_rddata), int'(exp));
    endtask

    task automatic configure(input logic [2:0] mode, input int vscale, input int hscale,
                             input logic enable, input int base, input int stride,
                             input logic [3:0] pal);
        write_reg(REG_BASE_LO, 8'(base));
        write_reg(REG_BASE_HI, 8'(base >> 8));
        write_reg(REG_STRIDE, 8'(stride));
        write_reg(REG_PALETTE, {4'd0, pal});
        write_reg(REG_CTRL0, {mode, 2'(vscale), 2'(hscale), enable});
        cfg_bpp    = (mode == MODE_BMP2) ? 2 : (mode == MODE_BMP4) ? 4 : 8;
        cfg_vscale = vscale;
        cfg_hscale = hscale;
        cfg_base   = base;
        cfg_stride = stride;
        cfg_pal    = pal;
    endtask

    task automatic pulse_screen();
        @(posedge clk);
        #1;
        start_of_screen = 1'b1;
        @(posedge clk);
        #1;
        start_of_screen = 1'b0;
        cur_line        = 0;
    endtask

    task automatic pulse_line();
        @(posedge clk);
        #1;
        start_of_line = 1'b1;
        @(posedge clk);
        #1;
        start_of_line = 1'b0;
    endtask

    task automatic render_line();
        int waited;
        wr_count  = 0;
        fetch_idx = 0;
        pulse_line();
        waited = 0;
        while (wr_count < LINE_PIXELS && waited < LINE_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (wr_count < LINE_PIXELS) begin
            timeouts++;
            $display("Timeout: line %0d stopped after %0d writes", cur_line, wr_count);
        end
        repeat (20) @(posedge clk);    // No writes past the line end
        assert (wr_count == LINE_PIXELS)
            else report_mismatch("line write count", wr_count, LINE_PIXELS);
        cur_line++;
    endtask

    // Line start that must leave bus and line buffer quiet
    task automatic check_idle_line();
        wr_count   = 0;
        strobe_cnt = 0;
        pulse_line();
        repeat (100) @(posedge clk);
        assert (strobe_cnt == 0) else report_mismatch("bus_strobe cycles", strobe_cnt, 0);
        assert (wr_count == 0) else report_mismatch("linebuf_wren cycles", wr_count, 0);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        rst             = 1'b1;
        start_of_screen = 1'b0;
        start_of_line   = 1'b0;
        regs_addr       = '0;
        regs_wrdata     = 8'd0;
        regs_write      = 1'b0;
        bus_rddata      = '0;
        bus_ack         = 1'b0;

        rng_state = 32'd85387;
        for (int i = 0; i < 65536; i++) begin
            rng_state = lcg_next(rng_state);
            mem[i]    = rng_state ^ {rng_state[15:0], 16'(i)};
        end

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // Register reset values and readback
        check_reg(REG_CTRL0, 8'h00);
        check_reg(REG_BASE_LO, 8'h00);
        check_reg(REG_BASE_HI, 8'h80);
        check_reg(REG_STRIDE, 8'h00);
        check_reg(REG_PALETTE, 8'h00);
        check_reg(4'd3, 8'h00);
        write_reg(REG_PALETTE, 8'hA5);
        check_reg(REG_PALETTE, 8'h05);     // Upper nibble not stored
        write_reg(4'd2, 8'hFF);
        check_reg(4'd2, 8'h00);
        write_reg(REG_CTRL0, 8'hEA);
        check_reg(REG_CTRL0, 8'hEA);
        write_reg(REG_BASE_LO, 8'h5C);
        check_reg(REG_BASE_LO, 8'h5C);
        write_reg(REG_CTRL0, 8'h00);

        // 8bpp, no scaling
        configure(MODE_BMP8, 0, 0, 1'b1, 16'h1000, 160, 4'h0);
        pulse_screen();
        repeat (3) render_line();

        // 2bpp and 4bpp with palette offset
        configure(MODE_BMP2, 0, 0, 1'b1, 16'h2345, 40, 4'hA);
        pulse_screen();
        repeat (2) render_line();
        configure(MODE_BMP4, 0, 0, 1'b1, 16'h4100, 80, 4'h6);
        pulse_screen();
        repeat (2) render_line();

        // Horizontal scaling
        configure(MODE_BMP8, 0, 1, 1'b1, 16'h5000, 80, 4'h0);
        pulse_screen();
        repeat (2) render_line();
        configure(MODE_BMP4, 0, 3, 1'b1, 16'h6000, 20, 4'h3);
        pulse_screen();
        repeat (2) render_line();

        // Vertical scaling and restart at base
        configure(MODE_BMP8, 2, 0, 1'b1, 16'h3000, 200, 4'h0);
        pulse_screen();
        repeat (7) render_line();
        pulse_screen();
        render_line();

        // Disabled layer and non-bitmap mode
        configure(MODE_BMP8, 0, 0, 1'b0, 16'h1000, 160, 4'h0);
        check_idle_line();
        configure(3'd3, 0, 0, 1'b1, 16'h1000, 160, 4'h0);
        check_idle_line();

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/layer_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_renderer
    import layer_cfg_pkg::*;
    import layer_mem_pkg::*;
#(
    parameter int LINE_PIXELS = 640
) (
    input  wire             clk,
    input  wire             rst,

    input  wire             start_of_screen,
    input  wire             start_of_line,

    // Register port
    input  wire reg_addr_t  regs_addr,
    input  wire [7:0]       regs_wrdata,
    input  wire             regs_write,
    output logic [7:0]      regs_rddata,

    // Bus master port
    output bus_addr_t       bus_addr,
    output logic            bus_strobe,
    input  wire bus_word_t  bus_rddata,
    input  wire             bus_ack,

    // Line buffer port
    output lb_idx_t         linebuf_wridx,
    output pixel_t          linebuf_wrdata,
    output logic            linebuf_wren
);

    layer_cfg_t cfg;

    pixel_word_if pw ();

    layer_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .regs_addr   (regs_addr),
        .regs_wrdata (regs_wrdata),
        .regs_write  (regs_write),
        .regs_rddata (regs_rddata),
        .cfg         (cfg)
    );

    bitmap_fetch u_fetch (
        .clk             (clk),
        .rst             (rst),
        .start_of_screen (start_of_screen),
        .start_of_line   (start_of_line),
        .cfg             (cfg),
        .bus_addr        (bus_addr),
        .bus_rddata      (bus_rddata),
        .bus_strobe      (bus_strobe),
        .bus_ack         (bus_ack),
        .pw              (pw.fetch)
    );

    pixel_unpack #(
        .LINE_PIXELS (LINE_PIXELS)
    ) u_unpack (
        .clk            (clk),
        .rst            (rst),
        .start_of_line  (start_of_line),
        .cfg            (cfg),
        .pw             (pw.unpack),
        .linebuf_wridx  (linebuf_wridx),
        .linebuf_wrdata (linebuf_wrdata),
        .linebuf_wren   (linebuf_wren)
    );

endmodule

`default_nettype wire

// ==== hdl/pixel_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_unpack
    import layer_cfg_pkg::*;
    import layer_mem_pkg::*;
#(
    parameter int LINE_PIXELS = 640
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             start_of_line,
    input  wire layer_cfg_t cfg,

    pixel_word_if.unpack    pw,

    output lb_idx_t         linebuf_wridx,
    output pixel_t          linebuf_wrdata,
    output logic            linebuf_wren
);

    localparam int CNT_W = $clog2(LINE_PIXELS + 1);

    logic             busy_r;
    bus_word_t        word_r;
    logic [3:0]       pal_r;
    logic [3:0]       xcnt_r;      // Pixel within word
    logic [1:0]       hcnt_r;      // Copy of current pixel
    logic [CNT_W-1:0] wr_cnt_r;    // Writes made on this line
    logic [3:0]       last_x;
    logic [4:0]       bit_off;
    pixel_t           raw_pix;
    logic             line_done;
    logic             last_write;

    assign line_done  = (wr_cnt_r == CNT_W'(LINE_PIXELS));
    assign last_write = (wr_cnt_r == CNT_W'(LINE_PIXELS - 1));

    assign pw.busy      = busy_r;
    assign pw.line_done = line_done;

    //////////////////////////////
    // Pixel select
    //////////////////////////////

    // Byte 0 first, upper field of each byte first
    always_comb begin
        case (cfg.depth)
            DEPTH_2: begin
                last_x  = 4'd15;
                bit_off = {xcnt_r[3:2], ~xcnt_r[1:0], 1'b0};
                raw_pix = {6'd0, word_r[bit_off +: 2]};
            end
            DEPTH_4: begin
                last_x  = 4'd7;
                bit_off = {xcnt_r[2:1], ~xcnt_r[0], 2'b00};
                raw_pix = {4'd0, word_r[bit_off +: 4]};
            end
            default: begin
                last_x  = 4'd3;
                bit_off = {xcnt_r[1:0], 3'b000};
                raw_pix = word_r[bit_off +: 8];
            end
        endcase
    end

    // Palette offset on nonzero 2 and 4 bpp pixels
    always_comb begin
        linebuf_wrdata = raw_pix;
        if (cfg.depth != DEPTH_8 && raw_pix != 8'd0)
            linebuf_wrdata[7:4] = pal_r;
    end

    assign linebuf_wren  = busy_r;
    assign linebuf_wridx = lb_idx_t'(wr_cnt_r);

    //////////////////////////////
    // Counters
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_r   <= 1'b0;
            xcnt_r   <= 4'd0;
            hcnt_r   <= 2'd0;
            wr_cnt_r <= '0;
        end else begin
            if (busy_r) begin
                wr_cnt_r <= wr_cnt_r + 1'b1;
                if (hcnt_r == cfg.hscale) begin
                    hcnt_r <= 2'd0;
                    if (xcnt_r == last_x) begin
                        busy_r <= 1'b0;    // Word used up
                        xcnt_r <= 4'd0;
                    end else begin
                        xcnt_r <= xcnt_r + 1'b1;
                    end
                end else begin
                    hcnt_r <= hcnt_r + 1'b1;
                end
                // Line full, rest of word dropped
                if (last_write) begin
                    busy_r <= 1'b0;
                    xcnt_r <= 4'd0;
                    hcnt_r <= 2'd0;
                end
            end else if (pw.start && !line_done) begin
                busy_r <= 1'b1;
                xcnt_r <= 4'd0;
                hcnt_r <= 2'd0;
            end

            if (start_of_line) begin
                busy_r   <= 1'b0;
                xcnt_r   <= 4'd0;
                hcnt_r   <= 2'd0;
                wr_cnt_r <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pw.start && !busy_r) begin
            word_r <= pw.word;
            pal_r  <= pw.palette_nib;
        end
    end

    // Never write past the end of the line
    assert property (@(posedge clk) disable iff (rst)
        linebuf_wren |-> (linebuf_wridx < LINE_PIXELS));

endmodule

`default_nettype wire

// ==== hdl/bitmap_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitmap_fetch
    import layer_cfg_pkg::*;
    import layer_mem_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             start_of_screen,
    input  wire             start_of_line,
    input  wire layer_cfg_t cfg,

    output bus_addr_t       bus_addr,
    input  wire bus_word_t  bus_rddata,
    output logic            bus_strobe,
    input  wire             bus_ack,

    pixel_word_if.fetch     pw
);

    typedef enum logic [1:0] {IDLE, FETCH, WAIT_ACK, HAND_OFF} state_t;

    state_t     state_r;
    logic       req_r;
    logic       start_r;
    bus_addr_t  line_addr_r;    // First word of current source line
    bus_addr_t  word_addr_r;    // Next word to read
    logic [1:0] vcnt_r;         // Repeat count of current source line
    bus_word_t  word_r;
    logic [3:0] palette_r;

    // Strobe drops in the ack cycle
    assign bus_strobe = req_r & ~bus_ack;

    assign pw.word        = word_r;
    assign pw.palette_nib = palette_r;
    assign pw.start       = start_r;

    //////////////////////////////
    // Fetch FSM
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_r     <= IDLE;
            req_r       <= 1'b0;
            start_r     <= 1'b0;
            bus_addr    <= '0;
            line_addr_r <= '0;
            word_addr_r <= '0;
            vcnt_r      <= 2'd0;
        end else begin
            start_r <= 1'b0;

            case (state_r)
                IDLE: ;

                FETCH: begin
                    if (pw.line_done) begin
                        state_r <= IDLE;
                    end else begin
                        bus_addr    <= word_addr_r;
                        word_addr_r <= word_addr_r + 1'b1;
                        req_r       <= 1'b1;
                        state_r     <= WAIT_ACK;
                    end
                end

                WAIT_ACK: begin
                    if (bus_ack) begin
                        req_r   <= 1'b0;
                        state_r <= HAND_OFF;
                    end
                end

                HAND_OFF: begin
                    if (pw.line_done) begin
                        state_r <= IDLE;    // Held word no longer needed
                    end else if (!pw.busy) begin
                        start_r <= 1'b1;
                        state_r <= FETCH;
                    end
                end

                default: state_r <= IDLE;
            endcase

            if (start_of_line) begin
                state_r     <= (cfg.enable && cfg.is_bitmap) ? FETCH : IDLE;
                req_r       <= 1'b0;
                start_r     <= 1'b0;
                word_addr_r <= line_addr_r;
                // Step to the next source line after vscale+1 repeats
                if (vcnt_r == cfg.vscale) begin
                    vcnt_r      <= 2'd0;
                    line_addr_r <= line_addr_r + {8'd0, cfg.stride};
                end else begin
                    vcnt_r <= vcnt_r + 1'b1;
                end
            end

            if (start_of_screen) begin
                line_addr_r <= cfg.base_addr;
                vcnt_r      <= 2'd0;
            end
        end
    end

    // Word and palette captured for the pixel stage
    always_ff @(posedge clk) begin
        if (state_r == WAIT_ACK && bus_ack)
            word_r <= bus_rddata;
        if (start_of_line)
            palette_r <= cfg.palette;
    end

    // Hand-off only when the pixel stage is free
    assert property (@(posedge clk) disable iff (rst) !(pw.start && pw.busy));

endmodule

`default_nettype wire

// ==== hdl/layer_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_regs
    import layer_cfg_pkg::*;
(
    input  wire             clk,
    input  wire             rst,

    input  wire reg_addr_t  regs_addr,
    input  wire [7:0]       regs_wrdata,
    input  wire             regs_write,
    output logic [7:0]      regs_rddata,

    output layer_cfg_t      cfg
);

    // CTRL0 fields
    logic [2:0]  mode_r;
    logic [1:0]  vscale_r;
    logic [1:0]  hscale_r;
    logic        enable_r;

    logic [15:0] base_r;
    logic [7:0]  stride_r;
    logic [3:0]  palette_r;

    logic        is_bitmap;
    depth_t      depth;

    //////////////////////////////
    // Readback
    //////////////////////////////

    always_comb begin
        case (regs_addr)
            REG_CTRL0:   regs_rddata = {mode_r, vscale_r, hscale_r, enable_r};
            REG_BASE_LO: regs_rddata = base_r[7:0];
            REG_BASE_HI: regs_rddata = base_r[15:8];
            REG_STRIDE:  regs_rddata = stride_r;
            REG_PALETTE: regs_rddata = {4'd0, palette_r};
            default:     regs_rddata = 8'h00;    // Unmapped
        endcase
    end

    //////////////////////////////
    // Writes
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode_r    <= 3'd0;
            vscale_r  <= 2'd0;
            hscale_r  <= 2'd0;
            enable_r  <= 1'b0;
            base_r    <= 16'h8000;
            stride_r  <= 8'd0;
            palette_r <= 4'd0;
        end else if (regs_write) begin
            case (regs_addr)
                REG_CTRL0: begin
                    mode_r   <= regs_wrdata[7:5];
                    vscale_r <= regs_wrdata[4:3];
                    hscale_r <= regs_wrdata[2:1];
                    enable_r <= regs_wrdata[0];
                end
                REG_BASE_LO: base_r[7:0]  <= regs_wrdata;
                REG_BASE_HI: base_r[15:8] <= regs_wrdata;
                REG_STRIDE:  stride_r     <= regs_wrdata;
                REG_PALETTE: palette_r    <= regs_wrdata[3:0];
                default: ;
            endcase
        end
    end

    // Only the bitmap modes render anything
    always_comb begin
        is_bitmap = 1'b1;
        case (mode_r)
            MODE_BMP2: depth = DEPTH_2;
            MODE_BMP4: depth = DEPTH_4;
            MODE_BMP8: depth = DEPTH_8;
            default: begin
                depth     = DEPTH_8;
                is_bitmap = 1'b0;
            end
        endcase
    end

    always_comb begin
        cfg.enable    = enable_r;
        cfg.is_bitmap = is_bitmap;
        cfg.depth     = depth;
        cfg.vscale    = vscale_r;
        cfg.hscale    = hscale_r;
        cfg.base_addr = base_r;
        cfg.stride    = stride_r;
        cfg.palette   = palette_r;
    end

endmodule

`default_nettype wire

// ==== hdl/pixel_word_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One fetched word on its way to the pixel stage
interface pixel_word_if
    import layer_mem_pkg::*;
();

    bus_word_t  word;
    logic [3:0] palette_nib;    // Palette offset for this word
    logic       start;          // One cycle, only while busy is low
    logic       busy;
    logic       line_done;      // Line buffer full

    modport fetch (
        output word,
        output palette_nib,
        output start,
        input  busy,
        input  line_done
    );

    modport unpack (
        input  word,
        input  palette_nib,
        input  start,
        output busy,
        output line_done
    );

endinterface

`default_nettype wire

// ==== hdl/layer_mem_pkg.sv ====
`default_nettype none

package layer_mem_pkg;

    localparam int BUS_ADDR_W = 16;
    localparam int BUS_DATA_W = 32;
    localparam int PIXEL_W    = 8;
    localparam int LB_IDX_W   = 10;    // Enough for 640 entries

    // Bus master side
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_word_t;

    // Line buffer side
    typedef logic [PIXEL_W-1:0]    pixel_t;
    typedef logic [LB_IDX_W-1:0]   lb_idx_t;

endpackage

`default_nettype wire

// ==== hdl/layer_cfg_pkg.sv ====
`default_nettype none

package layer_cfg_pkg;

    // Register port address
    typedef logic [3:0] reg_addr_t;

    //////////////////////////////
    // Register map
    //////////////////////////////

    localparam reg_addr_t REG_CTRL0   = 4'd0;    // Mode, scaling, enable
    localparam reg_addr_t REG_BASE_LO = 4'd4;
    localparam reg_addr_t REG_BASE_HI = 4'd5;
    localparam reg_addr_t REG_STRIDE  = 4'd6;    // Words per source line
    localparam reg_addr_t REG_PALETTE = 4'd7;    // Low nibble only

    // Bitmap mode codes in CTRL0[7:5]
    localparam logic [2:0] MODE_BMP2 = 3'd5;
    localparam logic [2:0] MODE_BMP4 = 3'd6;
    localparam logic [2:0] MODE_BMP8 = 3'd7;

    // Bits per pixel
    typedef enum logic [1:0] {
        DEPTH_2 = 2'd1,
        DEPTH_4 = 2'd2,
        DEPTH_8 = 2'd3
    } depth_t;

    // Decoded layer configuration
    typedef struct packed {
        logic        enable;
        logic        is_bitmap;
        depth_t      depth;
        logic [1:0]  vscale;     // Source line shown vscale+1 times
        logic [1:0]  hscale;     // Pixel written hscale+1 times
        logic [15:0] base_addr;
        logic [7:0]  stride;
        logic [3:0]  palette;
    } layer_cfg_t;

endpackage

`default_nettype wire
